/* gremlin_top.f */
+incdir+hw
hw/gremlin_pkg.sv
hw/gremlin_ram_if.sv
hw/gremlin_ram.sv
hw/gremlin_host_port.sv
hw/gremlin_core.sv
hw/gremlin_slot_timer.sv
hw/gremlin_top.sv
testbench/gremlin_clkgen.sv
testbench/gremlin_tb.sv

/* hw/gremlin_core.sv */
`include "gremlin_params.svh"

module gremlin_core
  import gremlin_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             run_i,
  input  logic             stall_i,
  input  logic             xfer_i,
  input  word_t            time_i,
  input  word_t            in_0_i,
  input  word_t            in_1_i,
  input  word_t            in_2_i,
  input  word_t            in_3_i,
  input  logic [1:0]       out_sel_i,
  output logic             halt_o,
  output logic             xfer_req_o,
  output word_t            out_0_o,
  output word_t            out_1_o,
  output word_t            out_2_o,
  output word_t            out_3_o,
  output word_t            out_sel_data_o,
  gremlin_ram_if.requester dmem_p,
  gremlin_ram_if.requester pmem_p
);

  localparam int AW = `GREMLIN_MEM_AW;

  logic          en;
  logic [AW-1:0] ip;                     // address of the word in fetch
  logic [AW-1:0] ip_nxt;
  logic          v_r;
  logic          v_o;
  logic          v_x;
  instr_t        instr_r;
  instr_t        instr_o;
  instr_t        instr_x;
  word_t         mem_data;
  word_t         mem_hold;
  logic          stall_q;
  word_t         operand_o;
  word_t         operand_x;
  word_t         acc;
  word_t         acc_nxt;
  word_t         sum;
  logic          carry_in;
  logic          cout;
  logic          save_carry;             // carry of the last add
  logic          last_carry;             // carry of the previous instruction
  logic [AW-1:0] index_q;
  logic          taken;
  logic          is_add;
  word_t         in_reg [4];
  word_t         out_reg [4];

  assign en      = run_i && !stall_i;
  assign instr_r = pmem_p.rdata;

  // ------------------------------------------------------------
  // fetch, a taken branch redirects the fetch after two more
  // ------------------------------------------------------------
  assign taken        = v_x && instr_x.br && (acc_nxt != '0);
  assign ip_nxt       = taken ? instr_x.addr : ip + 1'b1;
  assign pmem_p.re    = en;
  assign pmem_p.raddr = ip_nxt;

  // operand read, issued while the word is in fetch
  // index is seen by reads three instructions after op c
  assign dmem_p.re    = en && v_r;
  assign dmem_p.raddr = instr_r.idx ? index_q + instr_r.addr : instr_r.addr;
  assign mem_data     = stall_q ? mem_hold : dmem_p.rdata;

  always_comb
  begin
    case (instr_o.opsel)
      OPSEL_MEM:  operand_o = mem_data;
      OPSEL_INV:  operand_o = ~mem_data;
      OPSEL_ZERO: operand_o = '0;
      default:    operand_o = '1;
    endcase
  end

  // ------------------------------------------------------------
  // execute
  // ------------------------------------------------------------
  assign is_add = instr_x.op inside {OP_ADD0, OP_ADD1, OP_ADDS, OP_ADDC};

  always_comb
  begin
    case (instr_x.op)
      OP_ADD1: carry_in = 1'b1;
      OP_ADDS: carry_in = save_carry;
      OP_ADDC: carry_in = last_carry;
      default: carry_in = 1'b0;
    endcase
  end

  assign {cout, sum} = {1'b0, acc} + {1'b0, operand_x} + {16'd0, carry_in};

  always_comb
  begin
    case (instr_x.op)
      OP_ADD0, OP_ADD1, OP_ADDS, OP_ADDC: acc_nxt = sum;
      OP_LDTIME:          acc_nxt = time_i;
      OP_LDIN:            acc_nxt = in_reg[instr_x.addr[1:0]];
      OP_STCLR, OP_SETIDX: acc_nxt = '0;
      OP_AND:             acc_nxt = acc & operand_x;
      OP_OR:              acc_nxt = acc | operand_x;
      OP_XOR:             acc_nxt = acc ^ operand_x;
      default:            acc_nxt = acc;
    endcase
  end

  assign dmem_p.we    = en && v_x && (instr_x.op inside {OP_STORE, OP_STCLR});
  assign dmem_p.waddr = instr_x.idx ? index_q + instr_x.addr : instr_x.addr;
  assign dmem_p.wdata = acc;
  assign halt_o       = en && v_x && (instr_x.op == OP_HALT);
  assign xfer_req_o   = en && v_x && (instr_x.op == OP_OUTX);

  // pipeline restarts at address 0 whenever the run bit is low
  always_ff @(posedge CLK)
  begin
    if (!RST || !run_i)
    begin
      ip         <= '1;
      v_r        <= 1'b0;
      v_o        <= 1'b0;
      v_x        <= 1'b0;
      acc        <= '0;
      index_q    <= '0;
      save_carry <= 1'b0;
      last_carry <= 1'b0;
    end
    else if (en)
    begin
      ip  <= ip_nxt;
      v_r <= 1'b1;
      v_o <= v_r;
      v_x <= v_o;
      if (v_x)
      begin
        acc        <= acc_nxt;
        last_carry <= is_add && cout;
        if (is_add)
          save_carry <= cout;
        if (instr_x.op == OP_SETIDX)
          index_q <= acc[AW-1:0];
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (en)
    begin
      instr_o   <= instr_r;
      instr_x   <= instr_o;
      operand_x <= operand_o;
    end
    if (stall_i && !stall_q)
      mem_hold <= dmem_p.rdata;          // host is about to reuse the port
    if (xfer_i)
    begin
      in_reg[0] <= in_0_i;
      in_reg[1] <= in_1_i;
      in_reg[2] <= in_2_i;
      in_reg[3] <= in_3_i;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      stall_q <= 1'b0;
      out_reg <= '{default: '0};
    end
    else
    begin
      stall_q <= stall_i;
      if (en && v_x && (instr_x.op inside {OP_OUT, OP_OUTX}))
        out_reg[instr_x.addr[1:0]] <= acc;
    end
  end

  assign out_0_o        = out_reg[0];
  assign out_1_o        = out_reg[1];
  assign out_2_o        = out_reg[2];
  assign out_3_o        = out_reg[3];
  assign out_sel_data_o = out_reg[out_sel_i];

  a_stall_holds: assert property (
    @(posedge CLK) disable iff (!RST) stall_i |=> ($stable(ip) && $stable(acc))
  )
  else
    $error("pipeline advanced during a host stall");

endmodule

/* hw/gremlin_host_port.sv */
`include "gremlin_params.svh"

module gremlin_host_port
  import gremlin_pkg::*;
(
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic [`GREMLIN_MEM_AW+1:0]   adr_i,
  input  word_t                        dat_i,
  output word_t                        dat_o,
  output logic                         ack_o,
  input  logic                         halt_i,
  output logic                         run_o,
  output logic                         stall_o,
  output logic [1:0]                   out_sel_o,
  input  word_t                        out_data_i,
  gremlin_ram_if.memory                core_p,
  gremlin_ram_if.requester             ram_p,
  gremlin_ram_if.requester             pmem_p
);

  localparam int AW = `GREMLIN_MEM_AW;

  localparam logic [1:0] REG_DMEM = 2'b00;
  localparam logic [1:0] REG_PMEM = 2'b01;
  localparam logic [1:0] REG_CTRL = 2'b10;
  localparam logic [1:0] REG_OUT  = 2'b11;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,                             // data RAM read in flight
    ST_ACK
  } state_e;

  state_e        state;
  logic          req;
  logic [1:0]    region;
  logic [AW-1:0] word_adr;
  logic          host_dmem;

  assign req       = cyc_i && stb_i && (state == ST_IDLE);
  assign region    = adr_i[AW+1:AW];
  assign word_adr  = adr_i[AW-1:0];
  assign host_dmem = req && (region == REG_DMEM);
  assign stall_o   = host_dmem || (state == ST_READ);
  assign ack_o     = (state == ST_ACK); // one cycle, then back to idle
  assign out_sel_o = word_adr[1:0];

  // ------------------------------------------------------------
  // data RAM arbitration, host first
  // ------------------------------------------------------------
  always_comb
  begin
    if (host_dmem)
    begin
      ram_p.re    = !we_i;
      ram_p.raddr = word_adr;
      ram_p.we    = we_i;
      ram_p.waddr = word_adr;
      ram_p.wdata = dat_i;
    end
    else
    begin
      ram_p.re    = core_p.re;           // core is stalled in ST_READ
      ram_p.raddr = core_p.raddr;
      ram_p.we    = core_p.we;
      ram_p.waddr = core_p.waddr;
      ram_p.wdata = core_p.wdata;
    end
  end

  assign core_p.rdata = ram_p.rdata;

  // program memory, write side only
  assign pmem_p.we    = req && we_i && (region == REG_PMEM);
  assign pmem_p.waddr = word_adr;
  assign pmem_p.wdata = instr_t'(dat_i);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= ST_IDLE;
      run_o <= 1'b0;
    end
    else
    begin
      if (halt_i)
        run_o <= 1'b0;
      case (state)
        ST_IDLE:
          if (req)
          begin
            if (host_dmem && !we_i)
              state <= ST_READ;
            else
              state <= ST_ACK;
            if ((region == REG_CTRL) && we_i && dat_i[0])
              run_o <= 1'b1;
          end
        ST_READ: state <= ST_ACK;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // read data, the data RAM word arrives a cycle late
  always_ff @(posedge CLK)
  begin
    if (state == ST_READ)
      dat_o <= ram_p.rdata;
    else if (req && !we_i)
    begin
      case (region)
        REG_CTRL: dat_o <= {15'd0, run_o};
        REG_OUT:  dat_o <= out_data_i;
        REG_PMEM: dat_o <= '0;           // program memory is write only
        default:  dat_o <= dat_o;
      endcase
    end
  end

  a_ack_needs_stb: assert property (
    @(posedge CLK) disable iff (!RST) $rose(ack_o) |-> (cyc_i && stb_i)
  )
  else
    $error("ack raised without an active strobe");

endmodule

/* hw/gremlin_params.svh */
`ifndef GREMLIN_PARAMS_SVH
`define GREMLIN_PARAMS_SVH

// ------------------------------------------------------------
// memories
// ------------------------------------------------------------
`define GREMLIN_MEM_AW      8         // data and program address bits
`define GREMLIN_MEM_DEPTH   256       // words per memory

// ------------------------------------------------------------
// carousels
// ------------------------------------------------------------
`define GREMLIN_SMALL_W     8         // small carousel counter bits
`define GREMLIN_SMALL_LAST  8'd191    // small carousel wraps after this
`define GREMLIN_BIG_W       4         // big carousel counter bits
`define GREMLIN_SLOT0       8'd0      // first transfer slot, also refresh slot
`define GREMLIN_SLOT1       8'd96     // second transfer slot

`endif

/* hw/gremlin_pkg.sv */
`include "gremlin_params.svh"

package gremlin_pkg;

  typedef logic [15:0] word_t;

  // operand source of the operand-read stage
  typedef enum logic [1:0] {
    OPSEL_MEM  = 2'h0,
    OPSEL_INV  = 2'h1,                  // inverted memory word
    OPSEL_ZERO = 2'h2,
    OPSEL_ONES = 2'h3
  } opsel_e;

  typedef enum logic [3:0] {
    OP_ADD0   = 4'h0,                   // carry-in 0
    OP_ADD1   = 4'h1,                   // carry-in 1
    OP_ADDS   = 4'h2,                   // carry of the last add
    OP_ADDC   = 4'h3,                   // carry of the previous instruction
    OP_LDTIME = 4'h4,
    OP_LDIN   = 4'h5,
    OP_STORE  = 4'h6,
    OP_STCLR  = 4'h7,
    OP_NOP    = 4'h8,
    OP_HALT   = 4'h9,
    OP_OUT    = 4'ha,
    OP_OUTX   = 4'hb,                   // output plus transfer request
    OP_SETIDX = 4'hc,
    OP_AND    = 4'hd,
    OP_OR     = 4'he,
    OP_XOR    = 4'hf
  } opcode_e;

  typedef struct packed {
    logic                       br;     // branch if accumulator nonzero
    opsel_e                     opsel;
    logic                       idx;    // address plus index register
    opcode_e                    op;
    logic [`GREMLIN_MEM_AW-1:0] addr;
  } instr_t;

endpackage

/* hw/gremlin_ram.sv */
`include "gremlin_params.svh"

module gremlin_ram
  import gremlin_pkg::*;
#(
  parameter type payload_t = word_t
)
(
  input  logic          CLK,
  gremlin_ram_if.memory mem_p
);

  payload_t mem [`GREMLIN_MEM_DEPTH];

  // ------------------------------------------------------------
  // one write port, one registered read port
  // ------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (mem_p.we)
      mem[mem_p.waddr] <= mem_p.wdata;
  end

  // a read and a write to one address in the same cycle return the old word
  always_ff @(posedge CLK)
  begin
    if (mem_p.re)
      mem_p.rdata <= mem[mem_p.raddr];  // held while re is low
  end

  a_waddr_in_range: assert property (
    @(posedge CLK) mem_p.we |-> (32'(mem_p.waddr) < `GREMLIN_MEM_DEPTH)
  )
  else
    $error("write address beyond memory depth");

endmodule

/* hw/gremlin_ram_if.sv */
`include "gremlin_params.svh"

interface gremlin_ram_if
  import gremlin_pkg::*;
#(
  parameter type payload_t = word_t
)
();

  logic                       re;       // read enable
  logic [`GREMLIN_MEM_AW-1:0] raddr;
  payload_t                   rdata;    // valid the cycle after re
  logic                       we;
  logic [`GREMLIN_MEM_AW-1:0] waddr;
  payload_t                   wdata;

  modport requester (
    output re, raddr, we, waddr, wdata,
    input  rdata
  );

  modport memory (
    input  re, raddr, we, waddr, wdata,
    output rdata
  );

endinterface

/* hw/gremlin_slot_timer.sv */
`include "gremlin_params.svh"

module gremlin_slot_timer
  import gremlin_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  xfer_req_i,
  output logic  xfer_o,
  output word_t time_o,
  output logic  refresh_strobe_o
);

  logic [`GREMLIN_SMALL_W-1:0] small_q;
  logic [`GREMLIN_BIG_W-1:0]   big_q;
  logic                        pending_q;      // one transfer waiting for a slot
  logic                        refresh_due_q;  // refresh held off by a transfer
  logic                        wrap;
  logic                        at_slot;
  logic                        refresh_now;

  assign wrap        = (small_q == `GREMLIN_SMALL_LAST);
  assign at_slot     = (small_q == `GREMLIN_SLOT0) || (small_q == `GREMLIN_SLOT1);
  assign xfer_o      = pending_q && at_slot;
  assign refresh_now = refresh_due_q || ((small_q == `GREMLIN_SLOT0) && big_q[0]);

  // ------------------------------------------------------------
  // carousels, time register, transfer and refresh
  // ------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      small_q          <= `GREMLIN_SMALL_LAST;  // wraps to 0 on the first cycle
      big_q            <= '1;
      pending_q        <= 1'b0;
      refresh_due_q    <= 1'b0;
      refresh_strobe_o <= 1'b0;
      time_o           <= '0;
    end
    else
    begin
      time_o <= time_o - 16'd1;
      if (wrap)
      begin
        small_q <= '0;
        big_q   <= big_q + 1'b1;
      end
      else
        small_q <= small_q + 1'b1;

      pending_q <= xfer_req_i || (pending_q && !at_slot);

      if (refresh_now && !pending_q)
      begin
        refresh_strobe_o <= !refresh_strobe_o;
        refresh_due_q    <= 1'b0;
      end
      else if (refresh_now)
        refresh_due_q <= 1'b1;
    end
  end

endmodule

/* hw/gremlin_top.sv */
`include "gremlin_params.svh"

module gremlin_top
  import gremlin_pkg::*;
(
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [`GREMLIN_MEM_AW+1:0] adr_i,
  input  word_t                      dat_i,
  output word_t                      dat_o,
  output logic                       ack_o,
  output word_t                      out_0_o,
  output word_t                      out_1_o,
  output word_t                      out_2_o,
  output word_t                      out_3_o,
  input  word_t                      in_0_i,
  input  word_t                      in_1_i,
  input  word_t                      in_2_i,
  input  word_t                      in_3_i,
  output logic                       xfer_start_o,
  output logic                       refresh_strobe_o,
  output logic                       running_o
);

  gremlin_ram_if #(.payload_t(word_t))  dmem_core ();  // core side of the data RAM
  gremlin_ram_if #(.payload_t(word_t))  dmem_ram ();   // after host arbitration
  gremlin_ram_if #(.payload_t(instr_t)) pmem ();

  logic       run;
  logic       stall;
  logic       halt;
  logic       xfer;
  logic       xfer_req;
  word_t      time_w;
  logic [1:0] out_sel;
  word_t      out_sel_data;

  assign running_o    = run;
  assign xfer_start_o = xfer;

  gremlin_host_port u_host_port (
    .CLK        (CLK),
    .RST        (RST),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .we_i       (we_i),
    .adr_i      (adr_i),
    .dat_i      (dat_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .halt_i     (halt),
    .run_o      (run),
    .stall_o    (stall),
    .out_sel_o  (out_sel),
    .out_data_i (out_sel_data),
    .core_p     (dmem_core),
    .ram_p      (dmem_ram),
    .pmem_p     (pmem)
  );

  gremlin_core u_core (
    .CLK            (CLK),
    .RST            (RST),
    .run_i          (run),
    .stall_i        (stall),
    .xfer_i         (xfer),
    .time_i         (time_w),
    .in_0_i         (in_0_i),
    .in_1_i         (in_1_i),
    .in_2_i         (in_2_i),
    .in_3_i         (in_3_i),
    .out_sel_i      (out_sel),
    .halt_o         (halt),
    .xfer_req_o     (xfer_req),
    .out_0_o        (out_0_o),
    .out_1_o        (out_1_o),
    .out_2_o        (out_2_o),
    .out_3_o        (out_3_o),
    .out_sel_data_o (out_sel_data),
    .dmem_p         (dmem_core),
    .pmem_p         (pmem)
  );

  gremlin_slot_timer u_slot_timer (
    .CLK              (CLK),
    .RST              (RST),
    .xfer_req_i       (xfer_req),
    .xfer_o           (xfer),
    .time_o           (time_w),
    .refresh_strobe_o (refresh_strobe_o)
  );

  gremlin_ram #(.payload_t(word_t)) u_dmem (
    .CLK   (CLK),
    .mem_p (dmem_ram)
  );

  gremlin_ram #(.payload_t(instr_t)) u_pmem (
    .CLK   (CLK),
    .mem_p (pmem)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the gremlin testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f gremlin_top.f --top-module gremlin_tb -o gremlin_sim \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/gremlin_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* testbench/gremlin_clkgen.sv */
module gremlin_clkgen
(
  output logic CLK,
  output logic RST
);

  initial
  begin
    CLK = 1'b0;
    RST = 1'b0;                           // active low, held for 3 cycles
    repeat (3) @(posedge CLK);
    #1 RST = 1'b1;
  end

  always #2 CLK = ~CLK;                   // period 4

endmodule

/* testbench/gremlin_tb.sv */
`include "gremlin_params.svh"

module gremlin_tb
  import gremlin_pkg::*;
;

  localparam int CYCLE_LIMIT = 4000;      // test 5 alone needs 1536
  localparam logic [9:0] CTRL_ADR = 10'h200;

  logic       CLK;
  logic       RST;
  logic       cyc;
  logic       stb;
  logic       we;
  logic [`GREMLIN_MEM_AW+1:0] adr;
  word_t      dat_w;
  word_t      dat_r;
  logic       ack;
  word_t      out_0;
  word_t      out_1;
  word_t      out_2;
  word_t      out_3;
  word_t      in_0;
  word_t      in_1;
  word_t      in_2;
  word_t      in_3;
  logic       xfer_start;
  logic       refresh;
  logic       running;

  int         cycles;
  int         xfer_count;
  int         cur_test;
  int         test_errors;
  int         errors;
  int         tests_run;
  int         tests_failed;

  gremlin_clkgen u_clkgen (.CLK(CLK), .RST(RST));

  gremlin_top u_gremlin_top (
    .CLK (CLK), .RST (RST),
    .cyc_i (cyc), .stb_i (stb), .we_i (we), .adr_i (adr),
    .dat_i (dat_w), .dat_o (dat_r), .ack_o (ack),
    .out_0_o (out_0), .out_1_o (out_1), .out_2_o (out_2), .out_3_o (out_3),
    .in_0_i (in_0), .in_1_i (in_1), .in_2_i (in_2), .in_3_i (in_3),
    .xfer_start_o (xfer_start),
    .refresh_strobe_o (refresh),
    .running_o (running)
  );

  // ------------------------------------------------------------
  // cycle limit and transfer pulse counter
  // ------------------------------------------------------------
  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (RST && xfer_start)
      xfer_count <= xfer_count + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // host pattern, high byte is the address, low byte its inverse
  function automatic word_t fill_word(input logic [7:0] ad);
    return {ad, ~ad};
  endfunction

  task automatic bus_write(input logic [9:0] a, input word_t d);
    @(posedge CLK);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    @(negedge CLK);
    while (!ack)
      @(negedge CLK);
    @(posedge CLK);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_read(input logic [9:0] a, output word_t d);
    @(posedge CLK);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    @(negedge CLK);
    while (!ack)
      @(negedge CLK);
    d = dat_r;                            // sampled with ack
    @(posedge CLK);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    test_errors++;
  endtask

  task automatic close_test();
    if (cur_test > 0)
    begin
      tests_run++;
      if (test_errors == 0)
        $display("test %0d passed", cur_test);
      else
      begin
        $display("test %0d FAILED with %0d errors", cur_test, test_errors);
        tests_failed++;
      end
      errors += test_errors;
      test_errors = 0;
    end
  endtask

  // ------------------------------------------------------------
  // one line of the vectors file
  // ------------------------------------------------------------
  task automatic apply_vector(input logic [63:0] kind, input logic [31:0] a,
                              input logic [31:0] b);
    word_t      got;
    word_t      out_port;
    logic [7:0] ad;
    int         k;
    int         toggles;
    logic       prev;
    case (kind)
      "blk":
      begin
        for (k = 0; k < int'(b); k++)
        begin
          ad = a[7:0] + k[7:0];
          bus_write({2'b00, ad}, fill_word(ad));
        end
        for (k = 0; k < int'(b); k++)
        begin
          ad = a[7:0] + k[7:0];
          bus_read({2'b00, ad}, got);
          if (got !== fill_word(ad))
            report_mismatch($sformatf("dmem[%02h]", ad), got, fill_word(ad));
        end
      end
      "wr":  bus_write({2'b00, a[7:0]}, b[15:0]);
      "pg":  bus_write({2'b01, a[7:0]}, b[15:0]);
      "ctl":
      begin
        bus_read(CTRL_ADR, got);
        if (got !== b[15:0])
          report_mismatch("run bit", got, b[15:0]);
        if (running !== b[0])
          report_mismatch("running_o", word_t'(running), word_t'(b[0]));
      end
      "run":
      begin
        bus_write(CTRL_ADR, 16'h0001);
        while (running)
          @(negedge CLK);
      end
      "runw":
      begin
        bus_write(CTRL_ADR, 16'h0001);
        repeat (20) @(negedge CLK);       // well inside the loop
        bus_write({2'b00, a[7:0]}, b[15:0]);
        if (!running)
        begin
          $display("Error at %0t: program ended before the host write", $time);
          test_errors++;
        end
        while (running)
          @(negedge CLK);
      end
      "mem":
      begin
        bus_read({2'b00, a[7:0]}, got);
        if (got !== b[15:0])
          report_mismatch($sformatf("dmem[%02h]", a[7:0]), got, b[15:0]);
      end
      "out":
      begin
        bus_read({2'b11, 6'd0, a[1:0]}, got);
        if (got !== b[15:0])
          report_mismatch($sformatf("dat_o for out %0d", a[1:0]), got, b[15:0]);
        case (a[1:0])
          2'd0: out_port = out_0;
          2'd1: out_port = out_1;
          2'd2: out_port = out_2;
          default: out_port = out_3;
        endcase
        if (out_port !== b[15:0])
          report_mismatch($sformatf("out_%0d_o", a[1:0]), out_port, b[15:0]);
      end
      "in":
      begin
        @(posedge CLK);
        #1;
        case (a[1:0])
          2'd0: in_0 = b[15:0];
          2'd1: in_1 = b[15:0];
          2'd2: in_2 = b[15:0];
          default: in_3 = b[15:0];
        endcase
      end
      "xfr":
      begin
        while (xfer_count < int'(a))
          @(negedge CLK);
        repeat (2) @(negedge CLK);        // a longer pulse counts again
        if (xfer_count != int'(a))
          report_mismatch("xfer_start_o pulses", word_t'(xfer_count), a[15:0]);
      end
      "rfr":
      begin
        @(negedge CLK);
        prev    = refresh;
        toggles = 0;
        repeat (int'(a))
        begin
          @(negedge CLK);
          if (refresh != prev)
            toggles++;
          prev = refresh;
        end
        if ((toggles < int'(b) - 1) || (toggles > int'(b) + 1))
          report_mismatch("refresh_strobe_o toggles", word_t'(toggles), b[15:0]);
      end
      default:
      begin
        $display("unknown vector kind %0s in test %0d", kind, cur_test);
        test_errors++;
      end
    endcase
  endtask

  initial
  begin
    int           fd;
    int           rc;
    int           tnum;
    string        line;
    logic [63:0]  kind;
    logic [31:0]  a;
    logic [31:0]  b;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    adr = '0;
    dat_w = '0;
    in_0 = '0;
    in_1 = '0;
    in_2 = '0;
    in_3 = '0;
    cycles = 0;
    xfer_count = 0;
    cur_test = 0;
    test_errors = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    fd = $fopen("testbench/gremlin_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open testbench/gremlin_vectors.txt");
      $display("Simulation failed");
      $finish;
    end
    else
    begin
      wait (RST === 1'b1);
      while (!$feof(fd))
      begin
        line = "";
        rc = $fgets(line, fd);
        if ((rc > 0) && (line.len() > 0) && (line[0] != "#"))
        begin
          rc = $sscanf(line, "%d %s %h %h", tnum, kind, a, b);
          if (rc == 4)
          begin
            if (tnum != cur_test)
            begin
              close_test();
              cur_test = tnum;
            end
            apply_vector(kind, a, b);
          end
        end
      end
      close_test();
      $fclose(fd);
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if ((errors == 0) && (tests_failed == 0) && (tests_run > 0))
        $display("Simulation completed successfully");
      else
        $display("Simulation failed");
      $finish;
    end
  end

endmodule

/* testbench/gremlin_vectors.txt */
# columns: test kind a b  (a and b in hex)
# kinds: blk wr pg ctl run runw mem out in xfr rfr
1 blk 40 10
1 ctl 0 0
2 wr 0 1234
2 wr 1 ffff
2 wr 2 00f0
2 wr 3 0f0f
2 pg 0 0000
2 pg 1 0610
2 pg 2 0101
2 pg 3 0611
2 pg 4 4200
2 pg 5 0612
2 pg 6 6000
2 pg 7 4300
2 pg 8 0613
2 pg 9 0d03
2 pg a 0e02
2 pg b 2f02
2 pg c 0714
2 pg d 2000
2 pg e 0615
2 pg f 0900
2 run 0 0
2 mem 10 1234
2 mem 11 1234
2 mem 12 1235
2 mem 13 1235
2 mem 14 fdfa
2 mem 15 edcb
3 wr 20 0005
3 wr 36 aaaa
3 wr 56 aaaa
3 pg 0 0020
3 pg 1 0622
3 pg 2 0c00
3 pg 3 6000
3 pg 4 0800
3 pg 5 0022
3 pg 6 1630
3 pg 7 8801
3 pg 8 1650
3 pg 9 0800
3 pg a 0900
3 run 0 0
3 mem 31 0000
3 mem 32 0001
3 mem 33 0002
3 mem 34 0003
3 mem 35 0004
3 mem 36 aaaa
3 mem 51 0000
3 mem 55 0004
3 mem 56 aaaa
4 wr 60 1111
4 wr 61 2222
4 pg 0 0060
4 pg 1 0a00
4 pg 2 0061
4 pg 3 0a01
4 pg 4 0f60
4 pg 5 0a02
4 pg 6 6000
4 pg 7 0b03
4 pg 8 0900
4 in 0 a0a0
4 in 1 b1b1
4 in 2 c2c2
4 in 3 d3d3
4 run 0 0
4 out 0 1111
4 out 1 3333
4 out 2 2222
4 out 3 2221
4 xfr 1 0
4 in 0 5555
4 pg 0 0500
4 pg 1 0670
4 pg 2 0501
4 pg 3 0671
4 pg 4 0503
4 pg 5 0672
4 pg 6 0900
4 run 0 0
4 mem 70 a0a0
4 mem 71 b1b1
4 mem 72 d3d3
5 rfr 600 4
6 wr 20 0008
6 pg 0 0020
6 pg 1 0622
6 pg 2 0c00
6 pg 3 6000
6 pg 4 0800
6 pg 5 0022
6 pg 6 1630
6 pg 7 8801
6 pg 8 1650
6 pg 9 0800
6 pg a 0900
6 runw 80 7777
6 mem 80 7777
6 mem 38 0007
6 mem 37 0006
6 mem 36 0005
6 mem 31 0000
6 mem 58 0007
